// ==== compile.f ====
+incdir+logic
logic/usb_rx_pkg.sv
logic/usb_rx_edge_detect.sv
logic/usb_rx_timer.sv
logic/usb_rx_unpack.sv
logic/usb_rx_ctrl.sv
logic/usb_rx_top.sv
tb/usb_rx_chk.sv
tb/tb_usb_rx_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then search the log for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_usb_rx_top -f compile.f \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_usb_rx_top > sim.log 2>&1 || echo "simulator returned an error status"
grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== tb/tb_usb_rx_top.sv ====
`timescale 1ns/100ps
`include "usb_rx_defines.svh"

module tb_usb_rx_top;
	// Bits per test summed, each bit lasts 80 ns
	localparam int BIT_BUDGET = 40 + 40 + 60 + 50 + 3 * 80 + 4;
	localparam int WATCHDOG_NS = BIT_BUDGET * 80 + 2000;

	logic tb_clk;
	logic rst;
	logic d_plus;
	logic d_minus;
	logic receiving;
	logic [`USB_RX_BYTE_W-1:0] rx_data;
	logic rx_valid;
	logic rx_eop;
	logic rx_error;

	logic [31:0] lfsr_state = 32'h1ac8;
	// Encoder line level, 1 means J
	logic level_j = 1'b1;
	int ones_run = 0;
	logic drift_on = 1'b0;
	logic drift_long = 1'b0;
	logic [7:0] pkt_q[$];
	logic [7:0] exp_q[$];
	logic [7:0] rx_q[$];
	int eop_seen = 0;
	int error_seen = 0;
	int check_errs = 0;
	int tests_run = 0;
	int tests_bad = 0;

	usb_rx_top UUT (.*);
	bind usb_rx_top usb_rx_chk u_chk (.*);

	initial
	begin
		tb_clk = 1'b0;
		forever #5 tb_clk = ~tb_clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests completed");
		$display("tests failed");
		$finish;
	end

	// Collect every delivered byte and count the closing pulses
	always @(posedge tb_clk)
	begin
		if (rx_valid)
			rx_q.push_back(rx_data);
		if (rx_eop)
			eop_seen++;
		if (rx_error)
			error_seen++;
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic rand_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[6:0], lfsr_state[0]};
		end
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic drive_line(input logic dp, input logic dm, input int clks);
		d_plus = dp;
		d_minus = dm;
		repeat (clks) @(posedge tb_clk);
		#1;
	endtask

	// A zero toggles the line, drift alternates 7 and 9 clock bits
	task automatic send_bit(input logic b);
		int clks;
		clks = drift_on ? (drift_long ? 9 : 7) : `USB_RX_BIT_CLKS;
		if (!b)
			level_j = !level_j;
		drift_long = !drift_long;
		drive_line(level_j, !level_j, clks);
	endtask

	// LSB first with a zero stuffed after six ones in a row
	task automatic send_byte(input logic [7:0] b);
		for (int i = 0; i < 8; i++)
		begin
			send_bit(b[i]);
			ones_run = b[i] ? ones_run + 1 : 0;
			if (ones_run == `USB_RX_STUFF_RUN)
			begin
				send_bit(1'b0);
				ones_run = 0;
			end
		end
	endtask

	// SE0 for two bits then J idle
	task automatic send_eop();
		drive_line(1'b0, 1'b0, 2 * `USB_RX_BIT_CLKS);
		level_j = 1'b1;
		drive_line(1'b1, 1'b0, 4 * `USB_RX_BIT_CLKS);
	endtask

	// SYNC then pkt_q then EOP
	task automatic send_packet();
		level_j = 1'b1;
		ones_run = 0;
		send_byte(`USB_RX_SYNC);
		foreach (pkt_q[i])
		begin
			send_byte(pkt_q[i]);
			exp_q.push_back(pkt_q[i]);
		end
		pkt_q.delete();
		send_eop();
	endtask

	task automatic check_byte(input string name, input logic [`USB_RX_BYTE_W-1:0] got,
		input logic [`USB_RX_BYTE_W-1:0] exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			check_errs++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			check_errs++;
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
			check_errs++;
		end
	endtask

	// A packet ends with either rx_eop or rx_error
	task automatic wait_packet_ends(input int n);
		int waited;
		waited = 0;
		while (eop_seen + error_seen < n && waited < 400)
		begin
			@(posedge tb_clk);
			waited++;
		end
		#1;
		if (eop_seen + error_seen < n)
		begin
			$display("timed out waiting for the end of packet %0d", n);
			check_errs++;
		end
	endtask

	task automatic clear_counts();
		rx_q.delete();
		exp_q.delete();
		eop_seen = 0;
		error_seen = 0;
	endtask

	// Everything received since the last clear against what was sent
	task automatic expect_packets(input int n);
		wait_packet_ends(n);
		compare_count("rx_eop pulses", eop_seen, n);
		compare_count("rx_error pulses", error_seen, 0);
		compare_count("rx_valid pulses", rx_q.size(), exp_q.size());
		foreach (exp_q[i])
			if (i < rx_q.size())
				check_byte($sformatf("rx_data[%0d]", i), rx_q[i], exp_q[i]);
		check_flag("receiving", receiving, 1'b0);
		clear_counts();
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (check_errs != errs_before)
			tests_bad++;
		$display("test %s: %s", name, (check_errs == errs_before) ? "ok" : "FAILED");
	endtask

	task automatic basic_packet();
		int e0;
		e0 = check_errs;
		pkt_q = '{8'h3C, 8'hA5};
		send_packet();
		expect_packets(1);
		finish_test("basic_packet", e0);
	endtask

	// Both bytes need a stuffed zero, the run starts in SYNC
	task automatic stuffed_bytes();
		int e0;
		e0 = check_errs;
		pkt_q = '{8'hFF, 8'h7E};
		send_packet();
		expect_packets(1);
		finish_test("stuffed_bytes", e0);
	endtask

	// First byte is not SYNC then a clean packet follows
	task automatic bad_sync();
		int e0;
		e0 = check_errs;
		level_j = 1'b1;
		ones_run = 0;
		send_byte(8'h81);
		send_eop();
		wait_packet_ends(1);
		compare_count("rx_error pulses", error_seen, 1);
		compare_count("rx_eop pulses", eop_seen, 0);
		compare_count("rx_valid pulses", rx_q.size(), 0);
		check_flag("receiving", receiving, 1'b0);
		clear_counts();
		pkt_q = '{8'h5A};
		send_packet();
		expect_packets(1);
		finish_test("bad_sync", e0);
	endtask

	task automatic drift_resync();
		int e0;
		e0 = check_errs;
		drift_on = 1'b1;
		drift_long = 1'b0;
		pkt_q = '{8'hC3, 8'h0F, 8'h55};
		send_packet();
		drift_on = 1'b0;
		expect_packets(1);
		finish_test("drift_resync", e0);
	endtask

	task automatic random_packets();
		int e0;
		int n;
		logic [7:0] v;
		e0 = check_errs;
		for (int p = 0; p < 3; p++)
		begin
			rand_bits(3, v);
			n = int'(v % 6) + 1;
			for (int i = 0; i < n; i++)
			begin
				rand_bits(8, v);
				pkt_q.push_back(v);
			end
			send_packet();
		end
		expect_packets(3);
		finish_test("random_packets", e0);
	endtask

	initial
	begin
		rst = 1'b1;
		d_plus = 1'b1;
		d_minus = 1'b0;
		repeat (10) @(posedge tb_clk);
		#1;
		rst = 1'b0;
		drive_line(1'b1, 1'b0, 4 * `USB_RX_BIT_CLKS);
		basic_packet();
		stuffed_bytes();
		bad_sync();
		drift_resync();
		random_packets();
		$display("summary: %0d tests run, %0d failing, %0d check errors",
			tests_run, tests_bad, check_errs);
		if (check_errs == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== tb/usb_rx_chk.sv ====
`timescale 1ns/100ps

module usb_rx_chk
(
	input logic tb_clk,
	input logic rst,
	input logic receiving,
	input logic rx_valid,
	input logic rx_eop,
	input logic rx_error
);

	// Data bytes only come out of an open packet
	a_valid_in_packet: assert property (@(posedge tb_clk) disable iff (rst)
		rx_valid |-> receiving)
		else $error("rx_valid high while receiving is low");

	// One result pulse per clock at most
	a_pulses_exclusive: assert property (@(posedge tb_clk) disable iff (rst)
		$onehot0({rx_valid, rx_eop, rx_error}))
		else $error("rx_valid, rx_eop and rx_error overlap");

	// End of packet only closes a packet that was open
	a_eop_after_packet: assert property (@(posedge tb_clk) disable iff (rst)
		rx_eop |-> $past(receiving))
		else $error("rx_eop without receiving on the previous clock");

endmodule

// ==== logic/usb_rx_top.sv ====
`timescale 1ns/100ps
`include "usb_rx_defines.svh"

module usb_rx_top
(
	input  logic                      tb_clk,
	input  logic                      rst,
	input  logic                      d_plus,
	input  logic                      d_minus,
	output logic                      receiving,
	output logic [`USB_RX_BYTE_W-1:0] rx_data,
	output logic                      rx_valid,
	output logic                      rx_eop,
	output logic                      rx_error
);
	import usb_rx_pkg::*;

	// Pin front end to timer and control
	logic        d_edge;
	line_state_t line;
	// Timer strobes
	logic        bit_sample;
	logic        shift_enable;
	logic        byte_received;
	// Unpacker results
	logic        stuff_pending;
	logic [`USB_RX_BYTE_W-1:0] rx_byte;

	usb_rx_edge_detect u_edge (.tb_clk(tb_clk), .rst(rst), .d_plus(d_plus),
		.d_minus(d_minus), .d_edge(d_edge), .line(line));

	usb_rx_timer u_timer (.tb_clk(tb_clk), .rst(rst), .d_edge(d_edge),
		.receiving(receiving), .stuff_pending(stuff_pending), .bit_sample(bit_sample),
		.shift_enable(shift_enable), .byte_received(byte_received));

	usb_rx_unpack u_unpack (.tb_clk(tb_clk), .rst(rst), .receiving(receiving),
		.line(line), .bit_sample(bit_sample), .shift_enable(shift_enable),
		.stuff_pending(stuff_pending), .rx_byte(rx_byte));

	usb_rx_ctrl u_ctrl (.tb_clk(tb_clk), .rst(rst), .d_edge(d_edge), .line(line),
		.byte_received(byte_received), .rx_byte(rx_byte), .receiving(receiving),
		.rx_data(rx_data), .rx_valid(rx_valid), .rx_eop(rx_eop), .rx_error(rx_error));

endmodule

// ==== logic/usb_rx_ctrl.sv ====
`timescale 1ns/100ps
`include "usb_rx_defines.svh"

module usb_rx_ctrl
(
	input  logic                      tb_clk,
	input  logic                      rst,
	input  logic                      d_edge,
	input  usb_rx_pkg::line_state_t   line,
	input  logic                      byte_received,
	input  logic [`USB_RX_BYTE_W-1:0] rx_byte,
	output logic                      receiving,
	output logic [`USB_RX_BYTE_W-1:0] rx_data,
	output logic                      rx_valid,
	output logic                      rx_eop,
	output logic                      rx_error
);
	import usb_rx_pkg::*;

	rx_state_t state;
	rx_state_t next_state;

	// Pulse requests, registered below
	logic valid_set;
	logic eop_set;
	logic error_set;

	// Timer and unpacker run only while a packet is open
	assign receiving = (state == ST_SYNC) || (state == ST_DATA);

	always_comb
	begin
		next_state = state;
		valid_set  = 1'b0;
		eop_set    = 1'b0;
		error_set  = 1'b0;
		case (state)
			ST_IDLE:
			begin
				// J to K transition opens SYNC
				if (d_edge && (line == LS_K))
					next_state = ST_SYNC;
			end
			ST_SYNC:
			begin
				// First full byte must be the SYNC pattern
				if (byte_received)
				begin
					if (rx_byte == `USB_RX_SYNC)
						next_state = ST_DATA;
					else
					begin
						error_set  = 1'b1;
						next_state = ST_ERROR;
					end
				end
			end
			ST_DATA:
			begin
				// SE0 wins, a partial byte is dropped
				if (line == LS_SE0)
				begin
					eop_set    = 1'b1;
					next_state = ST_IDLE;
				end
				else if (byte_received)
					valid_set = 1'b1;
			end
			default:
			begin
				// Wait out the bad packet until the bus is J
				if (line == LS_J)
					next_state = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge tb_clk)
	begin
		if (rst)
		begin
			state    <= ST_IDLE;
			rx_valid <= 1'b0;
			rx_eop   <= 1'b0;
			rx_error <= 1'b0;
		end
		else
		begin
			state    <= next_state;
			rx_valid <= valid_set;
			rx_eop   <= eop_set;
			rx_error <= error_set;
		end
	end

	// Byte held until the next delivery
	always_ff @(posedge tb_clk)
	begin
		if (valid_set)
			rx_data <= rx_byte;
	end

endmodule

// ==== logic/usb_rx_unpack.sv ====
`timescale 1ns/100ps
`include "usb_rx_defines.svh"

module usb_rx_unpack
(
	input  logic                      tb_clk,
	input  logic                      rst,
	input  logic                      receiving,
	input  usb_rx_pkg::line_state_t   line,
	input  logic                      bit_sample,
	input  logic                      shift_enable,
	output logic                      stuff_pending,
	output logic [`USB_RX_BYTE_W-1:0] rx_byte
);
	import usb_rx_pkg::*;

	// Run counter must hold the full stuffing length
	localparam int RUN_W = $clog2(`USB_RX_STUFF_RUN + 1);
	localparam logic [RUN_W-1:0] RUN_LIMIT = RUN_W'(`USB_RX_STUFF_RUN);

	// Level seen at the previous sample
	line_state_t      prev_level;
	logic [RUN_W-1:0] ones_cnt;
	logic             data_bit;

	// NRZI: no change is a one, a change is a zero
	assign data_bit = (line == prev_level);

	// Next sampled bit is a stuffed zero
	assign stuff_pending = (ones_cnt == RUN_LIMIT);

	always_ff @(posedge tb_clk)
	begin
		if (rst)
		begin
			prev_level <= LS_J;
			ones_cnt   <= '0;
		end
		else if (!receiving)
		begin
			// Packet always starts from idle J
			prev_level <= LS_J;
			ones_cnt   <= '0;
		end
		else if (bit_sample)
		begin
			prev_level <= line;
			// Stuffed slot or a zero ends the run
			if (stuff_pending || !data_bit)
				ones_cnt <= '0;
			else
				ones_cnt <= ones_cnt + 1'b1;
		end
	end

	// Shift in at the top so the first bit lands in bit 0
	always_ff @(posedge tb_clk)
	begin
		if (shift_enable)
			rx_byte <= {data_bit, rx_byte[`USB_RX_BYTE_W-1:1]};
	end

endmodule

// ==== logic/usb_rx_timer.sv ====
`timescale 1ns/100ps
`include "usb_rx_defines.svh"

module usb_rx_timer
(
	input  logic tb_clk,
	input  logic rst,
	input  logic d_edge,
	input  logic receiving,
	input  logic stuff_pending,
	output logic bit_sample,
	output logic shift_enable,
	output logic byte_received
);

	// Phase counter covers one bus bit
	localparam int PHASE_W = $clog2(`USB_RX_BIT_CLKS);
	// Data bit counter covers one byte
	localparam int BITS_W  = $clog2(`USB_RX_BYTE_W);

	localparam logic [PHASE_W-1:0] PHASE_LAST   = PHASE_W'(`USB_RX_BIT_CLKS - 1);
	localparam logic [PHASE_W-1:0] PHASE_SAMPLE = PHASE_W'(`USB_RX_SAMPLE_PT);
	localparam logic [BITS_W-1:0]  BIT_LAST     = BITS_W'(`USB_RX_BYTE_W - 1);

	logic [PHASE_W-1:0] phase;
	logic [BITS_W-1:0]  bit_cnt;

	// Restart on every transition so the sample point tracks the sender
	always_ff @(posedge tb_clk)
	begin
		if (rst)
			phase <= '0;
		else if (!receiving || d_edge)
			phase <= '0;
		else if (phase == PHASE_LAST)
			phase <= '0;
		else
			phase <= phase + 1'b1;
	end

	// One sample per bit, mid-bit
	assign bit_sample   = receiving && (phase == PHASE_SAMPLE);
	// Stuffed bit is sampled but not shifted
	assign shift_enable = bit_sample && !stuff_pending;

	// Counts only shifted bits, stuffed ones do not advance it
	always_ff @(posedge tb_clk)
	begin
		if (rst)
		begin
			bit_cnt       <= '0;
			byte_received <= 1'b0;
		end
		else if (!receiving)
		begin
			bit_cnt       <= '0;
			byte_received <= 1'b0;
		end
		else
		begin
			if (shift_enable)
				bit_cnt <= bit_cnt + 1'b1;
			// One clock after the eighth shift
			byte_received <= shift_enable && (bit_cnt == BIT_LAST);
		end
	end

endmodule

// ==== logic/usb_rx_edge_detect.sv ====
`timescale 1ns/100ps

module usb_rx_edge_detect
(
	input  logic                    tb_clk,
	input  logic                    rst,
	input  logic                    d_plus,
	input  logic                    d_minus,
	output logic                    d_edge,
	output usb_rx_pkg::line_state_t line
);
	import usb_rx_pkg::*;

	// Two flop synchronizer stages per pin
	logic dp_meta;
	logic dp_sync;
	logic dm_meta;
	logic dm_sync;
	// History of synchronized D+ for transition detect
	logic dp_prev;

	always_ff @(posedge tb_clk)
	begin
		if (rst)
		begin
			// Bus idles in J, D+ high and D- low
			dp_meta <= 1'b1;
			dp_sync <= 1'b1;
			dm_meta <= 1'b0;
			dm_sync <= 1'b0;
			dp_prev <= 1'b1;
			d_edge  <= 1'b0;
			line    <= LS_J;
		end
		else
		begin
			dp_meta <= d_plus;
			dp_sync <= dp_meta;
			dm_meta <= d_minus;
			dm_sync <= dm_meta;
			dp_prev <= dp_sync;
			// Any change of D+ counts as a transition
			d_edge  <= dp_sync ^ dp_prev;
			// Classify pair, registered alongside d_edge
			case ({dp_sync, dm_sync})
				2'b10:   line <= LS_J;
				2'b01:   line <= LS_K;
				2'b00:   line <= LS_SE0;
				default: line <= LS_SE1;
			endcase
		end
	end

endmodule

// ==== logic/usb_rx_pkg.sv ====
package usb_rx_pkg;

	// Decoded differential pair
	// J is idle for full speed, SE0 marks end of packet
	typedef enum logic [1:0] {
		LS_J,
		LS_K,
		LS_SE0,
		LS_SE1
	} line_state_t;

	// Receiver packet state
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SYNC,
		ST_DATA,
		ST_ERROR
	} rx_state_t;

endpackage

// ==== logic/usb_rx_defines.svh ====
`ifndef USB_RX_DEFINES_SVH
`define USB_RX_DEFINES_SVH

// Clocks per full-speed bus bit
`define USB_RX_BIT_CLKS 8

// Phase count where a bit is sampled, near mid-bit
`define USB_RX_SAMPLE_PT 3

// Width of a received data byte
`define USB_RX_BYTE_W 8

// Ones in a row before the sender stuffs a zero
`define USB_RX_STUFF_RUN 6

// SYNC field after NRZI decoding, LSB first on the wire
`define USB_RX_SYNC 8'h80

`endif
